//--- src/rv32i_types_pkg.sv
package rv32i_types_pkg;

    // major opcodes of the base integer set.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [19:0] imm; // upper immediate or scrambled jump offset.
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uj_type_t;

    typedef union packed {
        r_type_t  r;
        uj_type_t uj;
    } inst_word_u;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic       uses_rs1;
        logic       uses_rs2;
        logic       writes_rd;
    } decode_info_t;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013; // addi x0, x0, 0.

endpackage

//--- src/rename_pkg.sv
package rename_pkg;

    localparam int PHYS_REG_BITS = 6;
    localparam int NUM_PHYS      = 64;
    localparam int NUM_ARCH      = 32;

    // registers beyond the architectural ones start out free.
    localparam int FREE_DEPTH    = NUM_PHYS - NUM_ARCH;

    typedef logic [PHYS_REG_BITS-1:0]  phys_reg_t;
    typedef logic [$clog2(NUM_ARCH)-1:0] arch_reg_t;

endpackage

//--- src/decode_if.sv
`timescale 1ns/10ps

interface decode_if;
    import rv32i_types_pkg::*;

    logic         valid;
    decode_info_t info;
    logic         stall; // held instruction cannot be renamed this cycle.

    modport decoder (
        output valid,
        output info,
        input  stall
    );

    modport rat (
        input  valid,
        input  info,
        output stall
    );

endinterface

//--- src/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] inst,
    input  logic        inst_valid,
    decode_if.decoder   dec
);
    import rv32i_types_pkg::*;

    inst_word_u   inst_q;
    logic         valid_q;
    decode_info_t info;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (!dec.stall) begin
            valid_q <= inst_valid;
        end
    end

    // the word itself is only meaningful while valid_q is set.
    always_ff @(posedge clk) begin
        if (!dec.stall) begin
            inst_q <= inst;
        end
    end

    always_comb begin
        info           = '0;
        info.opcode    = opcode_t'(inst_q.r.opcode);
        info.rs1       = inst_q.r.rs1;
        info.rs2       = inst_q.r.rs2;
        info.rd        = inst_q.r.rd;

        if (inst_q.uj.opcode inside {op_lui, op_auipc, op_jal}) begin
            info.writes_rd = 1'b1; // no source fields in this format.
        end else begin
            case (info.opcode)
                op_jalr, op_load, op_imm: begin
                    info.uses_rs1  = 1'b1;
                    info.writes_rd = 1'b1;
                end
                op_br, op_store: begin
                    info.uses_rs1 = 1'b1;
                    info.uses_rs2 = 1'b1;
                end
                op_reg: begin
                    info.uses_rs1  = 1'b1;
                    info.uses_rs2  = 1'b1;
                    info.writes_rd = 1'b1;
                end
                default: ; // unknown opcodes touch no registers.
            endcase
        end

        if (inst_q == '0 || inst_q == NOP_WORD) begin
            info.uses_rs1  = 1'b0;
            info.uses_rs2  = 1'b0;
            info.writes_rd = 1'b0;
        end

        if (info.rd == '0) info.writes_rd = 1'b0; // x0 is never renamed.
    end

    assign dec.valid = valid_q;
    assign dec.info  = info;

endmodule

//--- src/free_list.sv
`timescale 1ns/10ps

module free_list (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc,
    output rename_pkg::phys_reg_t alloc_pd,
    output logic                  empty,
    input  logic                  free_push,
    input  rename_pkg::phys_reg_t free_pd
);
    import rename_pkg::*;

    typedef logic [$clog2(FREE_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(FREE_DEPTH):0]   count_t;

    phys_reg_t entries [FREE_DEPTH];
    ptr_t      head;
    ptr_t      tail;
    count_t    count;
    logic      full;
    logic      pop;
    logic      push;

    assign empty = (count == '0);
    assign full  = (count == count_t'(FREE_DEPTH));
    assign pop   = alloc && !empty;
    assign push  = free_push && (!full || pop); // a pop frees the slot it leaves.

    assign alloc_pd = entries[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            // registers above the identity map start out unused.
            for (int i = 0; i < FREE_DEPTH; i++) begin
                entries[i] <= phys_reg_t'(NUM_ARCH + i);
            end
            head  <= '0;
            tail  <= '0; // full, so the tail has wrapped onto the head.
            count <= count_t'(FREE_DEPTH);
        end else begin
            if (push) begin
                entries[tail] <= free_pd;
                tail          <= tail + ptr_t'(1);
            end
            if (pop) begin
                head <= head + ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/rat.sv
`timescale 1ns/10ps

module rat (
    input  logic                  clk,
    input  logic                  rst,
    decode_if.rat                 dec,
    output logic                  alloc,
    input  rename_pkg::phys_reg_t alloc_pd,
    input  logic                  empty,
    input  logic                  cdb_valid,
    input  rename_pkg::arch_reg_t cdb_rd,
    input  rename_pkg::phys_reg_t cdb_pd,
    output logic                  rename_valid,
    output rename_pkg::phys_reg_t ps1,
    output rename_pkg::phys_reg_t ps2,
    output logic                  ps1_valid,
    output logic                  ps2_valid,
    output rename_pkg::phys_reg_t pd
);
    import rename_pkg::*;

    phys_reg_t           map [NUM_ARCH];
    logic [NUM_ARCH-1:0] ready;
    logic                wants_rd;
    logic                cdb_hit;

    assign wants_rd = dec.valid && dec.info.writes_rd;

    // only a writer can stall, and only when no register is left.
    assign dec.stall    = wants_rd && empty;
    assign rename_valid = dec.valid && !dec.stall;
    assign alloc        = wants_rd && !empty;

    assign pd = wants_rd ? alloc_pd : '0;

    // lookups read the state before this edge, so there is no CDB bypass.
    assign ps1       = dec.info.uses_rs1 ? map[dec.info.rs1] : '0;
    assign ps1_valid = dec.info.uses_rs1 ? ready[dec.info.rs1] : 1'b1;
    assign ps2       = dec.info.uses_rs2 ? map[dec.info.rs2] : '0;
    assign ps2_valid = dec.info.uses_rs2 ? ready[dec.info.rs2] : 1'b1;

    // a result for an older mapping of cdb_rd must not mark the new one ready.
    assign cdb_hit = cdb_valid && (cdb_rd != '0) && (map[cdb_rd] == cdb_pd);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                map[i] <= phys_reg_t'(i); // identity map.
            end
            ready <= '1;
        end else begin
            if (cdb_hit) begin
                ready[cdb_rd] <= 1'b1;
            end
            // the later assignment wins when both hit the same rd.
            if (alloc) begin
                map[dec.info.rd]   <= alloc_pd;
                ready[dec.info.rd] <= 1'b0;
            end
        end
    end

endmodule

//--- src/rename_stage.sv
`timescale 1ns/10ps

module rename_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           inst,
    input  logic                  inst_valid,
    output logic                  stall,
    input  logic                  free_push,
    input  rename_pkg::phys_reg_t free_pd,
    input  logic                  cdb_valid,
    input  rename_pkg::arch_reg_t cdb_rd,
    input  rename_pkg::phys_reg_t cdb_pd,
    output logic                  rename_valid,
    output rename_pkg::phys_reg_t ps1,
    output rename_pkg::phys_reg_t ps2,
    output logic                  ps1_valid,
    output logic                  ps2_valid,
    output rename_pkg::phys_reg_t pd
);
    import rename_pkg::*;

    decode_if  dif ();
    logic      alloc;
    logic      empty;
    phys_reg_t alloc_pd;

    assign stall = dif.stall; // upstream holds inst while this is high.

    inst_decoder dec0 (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .dec        (dif.decoder)
    );

    free_list fl0 (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .alloc_pd  (alloc_pd),
        .empty     (empty),
        .free_push (free_push),
        .free_pd   (free_pd)
    );

    rat rat0 (
        .clk          (clk),
        .rst          (rst),
        .dec          (dif.rat),
        .alloc        (alloc),
        .alloc_pd     (alloc_pd),
        .empty        (empty),
        .cdb_valid    (cdb_valid),
        .cdb_rd       (cdb_rd),
        .cdb_pd       (cdb_pd),
        .rename_valid (rename_valid),
        .ps1          (ps1),
        .ps2          (ps2),
        .ps1_valid    (ps1_valid),
        .ps2_valid    (ps2_valid),
        .pd           (pd)
    );

endmodule

//--- verif/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk; // free running, 50 percent duty.

endmodule

//--- verif/rename_properties.sv
`timescale 1ns/10ps

module rename_properties (
    input logic clk,
    input logic rst,
    input logic pop,
    input logic push,
    input logic empty,
    input logic full,
    input logic stall
);
    pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("register popped from an empty free list");

    // a push into a full list is only legal when a pop frees a slot.
    push_not_full: assert property (@(posedge clk) disable iff (rst) (push && full) |-> pop)
        else $error("register pushed into a full free list");

    stall_after_reset: assert property (@(posedge clk) rst ##1 !rst |-> !stall)
        else $error("stall high in the first cycle after reset");

    no_alloc_in_stall: assert property (@(posedge clk) disable iff (rst) !(pop && stall))
        else $error("allocation while stalled");

endmodule

bind free_list rename_properties props_fl (
    .clk(clk), .rst(rst), .pop(alloc), .push(free_push), .empty(empty), .full(full),
    .stall(1'b0)
);

bind rat rename_properties props_rat (
    .clk(clk), .rst(rst), .pop(alloc), .push(1'b0), .empty(empty), .full(1'b0),
    .stall(dec.stall)
);

//--- verif/rename_tb.sv
`timescale 1ns/10ps

module rename_tb;
    import rv32i_types_pkg::*;
    import rename_pkg::*;

    localparam int WAIT_LIMIT = 8;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic        inst_valid;
    logic        stall;
    logic        free_push;
    phys_reg_t   free_pd;
    logic        cdb_valid;
    arch_reg_t   cdb_rd;
    phys_reg_t   cdb_pd;
    logic        rename_valid;
    phys_reg_t   ps1;
    phys_reg_t   ps2;
    logic        ps1_valid;
    logic        ps2_valid;
    phys_reg_t   pd;

    int value_errors = 0;
    int other_errors = 0;

    // reference state of the alias table and free list.
    phys_reg_t m_map [NUM_ARCH];
    logic      m_ready [NUM_ARCH];
    phys_reg_t fl_q [$];

    clk_gen #(.PERIOD(100)) clk0 (.clk(clk));

    rename_stage dut0 (
        .clk(clk), .rst(rst), .inst(inst), .inst_valid(inst_valid), .stall(stall),
        .free_push(free_push), .free_pd(free_pd), .cdb_valid(cdb_valid), .cdb_rd(cdb_rd),
        .cdb_pd(cdb_pd), .rename_valid(rename_valid), .ps1(ps1), .ps2(ps2),
        .ps1_valid(ps1_valid), .ps2_valid(ps2_valid), .pd(pd)
    );

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] r_word(input opcode_t opc, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, opc};
    endfunction

    function automatic logic [31:0] u_word(input opcode_t opc, input logic [4:0] rd);
        return {20'hA5C3E, rd, opc};
    endfunction

    // register usage of a word, following the opcode rules of the stage.
    function automatic void expect_use(input logic [31:0] word, output logic u1,
                                       output logic u2, output logic w);
        u1 = 1'b0;
        u2 = 1'b0;
        w  = 1'b0;
        case (word[6:0])
            op_lui, op_auipc, op_jal: w = 1'b1;
            op_jalr, op_load, op_imm: begin
                u1 = 1'b1;
                w  = 1'b1;
            end
            op_br, op_store: begin
                u1 = 1'b1;
                u2 = 1'b1;
            end
            op_reg: begin
                u1 = 1'b1;
                u2 = 1'b1;
                w  = 1'b1;
            end
            default: ;
        endcase
        if (word == 32'h0 || word == NOP_WORD) begin
            u1 = 1'b0;
            u2 = 1'b0;
            w  = 1'b0;
        end
        if (word[11:7] == 5'd0) w = 1'b0;
    endfunction

    task automatic model_reset();
        fl_q = {};
        for (int i = 0; i < NUM_ARCH; i++) begin
            m_map[i]   = phys_reg_t'(i);
            m_ready[i] = 1'b1;
            fl_q.push_back(phys_reg_t'(NUM_ARCH + i));
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        model_reset();
    endtask

    task automatic issue(input logic [31:0] word);
        logic u1;
        logic u2;
        logic w;
        logic exp_stall;
        int   n;
        expect_use(word, u1, u2, w);
        exp_stall = w && (fl_q.size() == 0);
        @(negedge clk);
        inst       = word;
        inst_valid = 1'b1;
        @(negedge clk);
        inst_valid = 1'b0; // taken at the edge just passed.
        n = 0;
        while (!rename_valid && !stall && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            other_errors++;
            $display("instruction %h got neither a rename nor a stall in time", word);
        end
        check_val("stall", stall, exp_stall);
        check_val("rename_valid", rename_valid, !exp_stall);
        check_val("ps1", ps1, u1 ? m_map[word[19:15]] : '0);
        check_val("ps1_valid", ps1_valid, u1 ? m_ready[word[19:15]] : 1'b1);
        check_val("ps2", ps2, u2 ? m_map[word[24:20]] : '0);
        check_val("ps2_valid", ps2_valid, u2 ? m_ready[word[24:20]] : 1'b1);
        if (!exp_stall) check_val("pd", pd, w ? fl_q[0] : '0);
    endtask

    task automatic commit(input logic [31:0] word);
        logic u1;
        logic u2;
        logic w;
        expect_use(word, u1, u2, w);
        if (w) begin
            m_map[word[11:7]]   = fl_q.pop_front();
            m_ready[word[11:7]] = 1'b0;
        end
    endtask

    // drives the CDB at the current falling edge, the caller releases it.
    task automatic drive_cdb(input arch_reg_t rd, input phys_reg_t p);
        cdb_valid = 1'b1;
        cdb_rd    = rd;
        cdb_pd    = p;
        if (rd != '0 && m_map[rd] == p) m_ready[rd] = 1'b1;
    endtask

    task automatic cdb_write(input arch_reg_t rd, input phys_reg_t p);
        @(negedge clk);
        drive_cdb(rd, p);
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    task automatic issue_commit(input logic [31:0] word);
        issue(word);
        commit(word);
    endtask

    task automatic test_reset_identity();
        logic [31:0] w;
        for (int i = 0; i < 8; i++) begin
            w = r_word(op_reg, 5'd0, 5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)));
            issue_commit(w);
        end
    endtask

    task automatic test_rename_order();
        logic [31:0] w;
        for (int i = 1; i <= 4; i++) begin
            w = r_word(op_reg, 5'(i), 5'd10, 5'd11);
            issue(w);
            check_val("pd", pd, 32'(NUM_ARCH + i - 1)); // allocation starts at p32.
            commit(w);
            issue_commit(r_word(op_reg, 5'd0, 5'(i), 5'(i))); // sees new pd, not ready.
        end
        issue_commit(r_word(op_imm, 5'd0, 5'd3, 5'd0)); // x0 allocates nothing.
        issue_commit(r_word(op_reg, 5'd6, 5'd1, 5'd2));
    endtask

    task automatic test_cdb_wakeup();
        logic [31:0] w;
        phys_reg_t   old_p;
        issue_commit(r_word(op_reg, 5'd7, 5'd1, 5'd2));
        cdb_write(5'd7, m_map[7]);
        issue_commit(r_word(op_br, 5'd0, 5'd7, 5'd7));
        old_p = m_map[7];
        issue_commit(r_word(op_reg, 5'd7, 5'd3, 5'd4));
        cdb_write(5'd7, old_p); // stale tag.
        cdb_write(5'd0, '0);
        issue_commit(r_word(op_reg, 5'd0, 5'd7, 5'd0));
        w = r_word(op_reg, 5'd7, 5'd5, 5'd6);
        issue(w);
        drive_cdb(5'd7, m_map[7]); // same edge as the rename.
        commit(w);
        @(negedge clk);
        cdb_valid = 1'b0;
        issue_commit(r_word(op_reg, 5'd0, 5'd7, 5'd0));
    endtask

    task automatic test_source_usage();
        issue_commit(u_word(op_jal, 5'd3));
        issue_commit(u_word(op_lui, 5'd4));
        issue_commit(r_word(op_imm, 5'd8, 5'd3, 5'd4));
        issue_commit(r_word(op_jalr, 5'd9, 5'd4, 5'd3));
        issue_commit(r_word(op_br, 5'd0, 5'd3, 5'd4));
        issue_commit(32'h0);
        issue_commit(NOP_WORD);
    endtask

    task automatic test_exhaustion();
        logic [31:0] w;
        phys_reg_t   ret [3];
        int          n;
        apply_reset();
        for (int i = 0; i < FREE_DEPTH; i++) begin
            issue_commit(r_word(op_reg, 5'(i % 31 + 1), 5'd0, 5'd0));
        end
        issue_commit(r_word(op_store, 5'd0, 5'd1, 5'd2));
        w = r_word(op_reg, 5'd9, 5'd1, 5'd2);
        issue(w);
        @(negedge clk);
        check_val("stall held", stall, 1'b1);
        check_val("rename_valid held", rename_valid, 1'b0);
        for (int k = 0; k < 3; k++) ret[k] = phys_reg_t'($urandom_range(1, 63));
        free_push = 1'b1;
        free_pd   = ret[0];
        fl_q.push_back(ret[0]);
        @(negedge clk);
        free_push = 1'b0;
        n = 0;
        while (stall && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            other_errors++;
            $display("stall did not drop after a register was returned");
        end
        check_val("rename_valid", rename_valid, 1'b1);
        check_val("pd", pd, ret[0]);
        commit(w);
        for (int k = 1; k < 3; k++) begin
            @(negedge clk);
            free_push = 1'b1;
            free_pd   = ret[k];
            fl_q.push_back(ret[k]);
        end
        @(negedge clk);
        free_push = 1'b0;
        for (int k = 1; k < 3; k++) begin
            w = r_word(op_reg, 5'(k + 10), 5'd0, 5'd0);
            issue(w);
            check_val("return order", pd, ret[k]); // returns come back in FIFO order.
            commit(w);
        end
    endtask

    initial begin
        void'($urandom(57));
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        free_push  = 1'b0;
        free_pd    = '0;
        cdb_valid  = 1'b0;
        cdb_rd     = '0;
        cdb_pd     = '0;
        apply_reset();
        test_reset_identity();
        test_rename_order();
        test_cdb_wakeup();
        test_source_usage();
        test_exhaustion();
        $display("%0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- all.f
src/rv32i_types_pkg.sv
src/rename_pkg.sv
src/decode_if.sv
src/inst_decoder.sv
src/free_list.sv
src/rat.sv
src/rename_stage.sv
verif/clk_gen.sv
verif/rename_properties.sv
verif/rename_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
